//--- Makefile
# Verilator build for the PET bus front end

LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module pet_bus_tb
	verilator --lint-only hw/bus_pkg.sv hw/host_pkg.sv hw/phi2_gen.sv hw/bus_arbiter.sv \
		hw/bus_pins.sv hw/pet_ram.sv hw/pet_bus_top.sv --top-module pet_bus_top

sim:
	verilator --binary --timing --assert -f tb.f --top-module pet_bus_tb -o simv
	./obj_dir/simv > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- hw/bus_arbiter.sv
// ******************************
// bus_arbiter
// takes host commands and steals or
// holds cpu bus cycles through RDY
// returns the byte read in a stolen
// cycle along with a done pulse
// ******************************

module bus_arbiter (
    input  logic                            cpu_clock_ne,   // system clock
    input  logic                            arst_n_i,
    input  logic                            phi2_fall_i,    // bus cycle boundary
    input  logic                            host_strobe_i,
    input  host_pkg::host_op_e              host_op_i,
    input  logic [bus_pkg::CPU_ADDR_WIDTH-1:0] host_addr_i,
    input  logic [bus_pkg::DATA_WIDTH-1:0]     host_data_i,
    input  logic [bus_pkg::DATA_WIDTH-1:0]     ram_rdata_i,
    output logic                            host_sel_o,     // host owns this bus cycle
    output logic                            host_we_o,      // host cycle is a write
    output logic [bus_pkg::CPU_ADDR_WIDTH-1:0] req_addr_o,
    output logic [bus_pkg::DATA_WIDTH-1:0]     req_data_o,
    output logic                            cpu_ready_o,    // 6502 RDY
    output logic                            host_busy_o,
    output logic                            host_done_o,
    output logic [bus_pkg::DATA_WIDTH-1:0]     host_rdata_o
);
    import host_pkg::*;

    arb_state_e state_q;
    arb_state_e state_next;

    logic accept;           // strobe taken while not busy
    logic accept_rw;        // accepted strobe is a read or write
    logic steal_end;        // fall that closes the stolen cycle
    logic hold_req_q;       // last HOLD/RUN command
    logic hold_next;
    logic hold_q;           // hold as seen by the cpu, moves at falls only

    assign accept    = host_strobe_i && (state_q == ARB_IDLE);
    assign steal_end = (state_q == ARB_STEAL) && phi2_fall_i;

    // command decode
    always_comb begin
        accept_rw = 1'b0;
        hold_next = hold_req_q;
        if (accept) begin
            case (host_op_i)
                OP_READ, OP_WRITE: accept_rw = 1'b1;
                OP_HOLD:           hold_next = 1'b1;
                OP_RUN:            hold_next = 1'b0;
                default:           hold_next = hold_req_q;  // nop
            endcase
        end
    end

    // a request landing on a fall claims the cycle that fall opens
    always_comb begin
        state_next = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (accept_rw) begin
                    state_next = phi2_fall_i ? ARB_STEAL : ARB_PENDING;
                end
            end
            ARB_PENDING: begin
                if (phi2_fall_i) begin
                    state_next = ARB_STEAL;
                end
            end
            ARB_STEAL: begin
                if (phi2_fall_i) begin
                    state_next = ARB_IDLE;      // ram has committed, data collected
                end
            end
            default: state_next = ARB_IDLE;
        endcase
    end

    always_ff @(posedge cpu_clock_ne or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= ARB_IDLE;
            hold_req_q  <= 1'b0;
            hold_q      <= 1'b0;
            host_done_o <= 1'b0;
        end else begin
            state_q     <= state_next;
            hold_req_q  <= hold_next;
            host_done_o <= steal_end;           // pulse right after the closing fall
            if (phi2_fall_i) begin
                hold_q <= hold_next;
            end
        end
    end

    // request and read data registers
    always_ff @(posedge cpu_clock_ne) begin
        if (accept_rw) begin
            req_addr_o <= host_addr_i;
            req_data_o <= host_data_i;
            host_we_o  <= (host_op_i == OP_WRITE);
        end
        if (steal_end) begin
            host_rdata_o <= ram_rdata_i;        // read of the stolen cycle
        end
    end

    assign host_sel_o  = (state_q == ARB_STEAL);
    assign host_busy_o = (state_q != ARB_IDLE);
    assign cpu_ready_o = !(host_sel_o || hold_q);  // both only move at falls

endmodule

//--- hw/bus_pins.sv
// ******************************
// bus_pins
// drives address, data and write
// enable onto the bus one system
// cycle after the PHI2 fall, taken
// from the cpu or the host request
// ******************************

module bus_pins (
    input  logic                               cpu_clock_ne,    // system clock
    input  logic                               arst_n_i,
    input  logic                               phi2_fall_i,
    input  logic [bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [bus_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    input  logic                               cpu_we_n_i,      // active low from the cpu
    input  logic                               host_sel_i,
    input  logic                               host_we_i,       // active high from the host
    input  logic [bus_pkg::CPU_ADDR_WIDTH-1:0] req_addr_i,
    input  logic [bus_pkg::DATA_WIDTH-1:0]     req_data_i,
    output logic [bus_pkg::CPU_ADDR_WIDTH-1:0] bus_addr_o,
    output logic [bus_pkg::DATA_WIDTH-1:0]     bus_data_o,
    output logic                               bus_we_n_o
);
    import bus_pkg::*;

    logic                      fall_q;      // fall strobe one cycle late
    logic [CPU_ADDR_WIDTH-1:0] addr_next;
    logic [DATA_WIDTH-1:0]     data_next;
    logic                      we_n_next;

    // source select
    always_comb begin
        if (host_sel_i) begin
            addr_next = req_addr_i;
            data_next = req_data_i;
            we_n_next = !host_we_i;     // host write is active high
        end else begin
            addr_next = cpu_addr_i;
            data_next = cpu_data_i;
            we_n_next = cpu_we_n_i;
        end
    end

    // the 65C02 moves its outputs a little after PHI2 falls
    // one system cycle of delay models that
    always_ff @(posedge cpu_clock_ne or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fall_q     <= 1'b0;
            bus_addr_o <= '0;
            bus_data_o <= '0;
            bus_we_n_o <= 1'b1;         // read cycle after reset
        end else begin
            fall_q <= phi2_fall_i;
            if (fall_q) begin
                bus_addr_o <= addr_next;    // held for the whole bus cycle
                bus_data_o <= data_next;
                bus_we_n_o <= we_n_next;
            end
        end
    end

endmodule

//--- hw/bus_pkg.sv
// ******************************
// bus_pkg
// widths and sizes of the PET CPU bus
// plus the PHI2 divider constants
// ******************************

package bus_pkg;

    // cpu side of the bus
    localparam int CPU_ADDR_WIDTH = 16;     // 6502 address pins
    localparam int DATA_WIDTH     = 8;      // 6502 data pins

    // 4 KiB of RAM mirrored over the whole 64 KiB map
    localparam int RAM_ADDR_WIDTH = 12;
    localparam int RAM_DEPTH      = 1 << RAM_ADDR_WIDTH;

    // system clocks per PHI2 period
    // phi2 low in the first half and high in the second half
    localparam int PHI2_DIV       = 8;
    localparam int PHI2_HALF      = PHI2_DIV / 2;
    localparam int PHI2_CNT_WIDTH = $clog2(PHI2_DIV);   // phase counter width

endpackage

//--- hw/host_pkg.sv
// ******************************
// host_pkg
// host command opcodes and the
// bus arbiter state encoding
// ******************************

package host_pkg;

    // commands on host_op_i, sampled with host_strobe_i
    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,    // strobe does nothing
        OP_READ  = 3'd1,    // steal one bus cycle and read a byte
        OP_WRITE = 3'd2,    // steal one bus cycle and write a byte
        OP_HOLD  = 3'd3,    // park the cpu with RDY low
        OP_RUN   = 3'd4     // let the cpu go again
    } host_op_e;

    // arbiter FSM
    typedef enum logic [1:0] {
        ARB_IDLE    = 2'd0, // no host access outstanding
        ARB_PENDING = 2'd1, // request latched, waiting for the phi2 fall
        ARB_STEAL   = 2'd2  // bus cycle belongs to the host
    } arb_state_e;

endpackage

//--- hw/pet_bus_top.sv
// ******************************
// pet_bus_top
// PET cpu bus front end with PHI2
// generation, host cycle stealing,
// bus pin timing and RAM
// ******************************

module pet_bus_top (
    input  logic                               cpu_clock_ne,    // system clock
    input  logic                               arst_n_i,
    input  logic [bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [bus_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    input  logic                               cpu_we_n_i,
    output logic                               cpu_ready_o,
    output logic                               cpu_clock_o,     // PHI2 to the cpu
    output logic [bus_pkg::CPU_ADDR_WIDTH-1:0] bus_addr_o,
    output logic [bus_pkg::DATA_WIDTH-1:0]     bus_data_o,
    output logic                               bus_we_n_o,
    output logic [bus_pkg::DATA_WIDTH-1:0]     bus_rdata_o,
    input  logic                               host_strobe_i,
    input  host_pkg::host_op_e                 host_op_i,
    input  logic [bus_pkg::CPU_ADDR_WIDTH-1:0] host_addr_i,
    input  logic [bus_pkg::DATA_WIDTH-1:0]     host_data_i,
    output logic                               host_busy_o,
    output logic                               host_done_o,
    output logic [bus_pkg::DATA_WIDTH-1:0]     host_rdata_o
);
    import bus_pkg::*;

    logic                      phi2_fall;   // bus cycle boundary
    logic                      host_sel;
    logic                      host_we;
    logic [CPU_ADDR_WIDTH-1:0] req_addr;
    logic [DATA_WIDTH-1:0]     req_data;

    phi2_gen phi2_gen_inst (
        .cpu_clock_ne (cpu_clock_ne),
        .arst_n_i     (arst_n_i),
        .phi2_o       (cpu_clock_o),
        .phi2_fall_o  (phi2_fall)
    );

    bus_arbiter bus_arbiter_inst (
        .cpu_clock_ne  (cpu_clock_ne),
        .arst_n_i      (arst_n_i),
        .phi2_fall_i   (phi2_fall),
        .host_strobe_i (host_strobe_i),
        .host_op_i     (host_op_i),
        .host_addr_i   (host_addr_i),
        .host_data_i   (host_data_i),
        .ram_rdata_i   (bus_rdata_o),
        .host_sel_o    (host_sel),
        .host_we_o     (host_we),
        .req_addr_o    (req_addr),
        .req_data_o    (req_data),
        .cpu_ready_o   (cpu_ready_o),
        .host_busy_o   (host_busy_o),
        .host_done_o   (host_done_o),
        .host_rdata_o  (host_rdata_o)
    );

    bus_pins bus_pins_inst (
        .cpu_clock_ne (cpu_clock_ne),
        .arst_n_i     (arst_n_i),
        .phi2_fall_i  (phi2_fall),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_data_i   (cpu_data_i),
        .cpu_we_n_i   (cpu_we_n_i),
        .host_sel_i   (host_sel),
        .host_we_i    (host_we),
        .req_addr_i   (req_addr),
        .req_data_i   (req_data),
        .bus_addr_o   (bus_addr_o),
        .bus_data_o   (bus_data_o),
        .bus_we_n_o   (bus_we_n_o)
    );

    pet_ram pet_ram_inst (
        .cpu_clock_ne (cpu_clock_ne),
        .phi2_fall_i  (phi2_fall),
        .addr_i       (bus_addr_o),
        .data_i       (bus_data_o),
        .we_n_i       (bus_we_n_o),
        .rdata_o      (bus_rdata_o)
    );

endmodule

//--- hw/pet_ram.sv
// ******************************
// pet_ram
// 4 KiB RAM mirrored over the cpu
// address space, commits a write at
// the fall that ends the bus cycle
// ******************************

module pet_ram (
    input  logic                               cpu_clock_ne,    // system clock
    input  logic                               phi2_fall_i,     // end of bus cycle
    input  logic [bus_pkg::CPU_ADDR_WIDTH-1:0] addr_i,
    input  logic [bus_pkg::DATA_WIDTH-1:0]     data_i,
    input  logic                               we_n_i,
    output logic [bus_pkg::DATA_WIDTH-1:0]     rdata_o
);
    import bus_pkg::*;

    logic [DATA_WIDTH-1:0]     mem [RAM_DEPTH];
    logic [RAM_ADDR_WIDTH-1:0] ram_addr;

    // upper address bits dropped, so every 4 KiB block maps here
    assign ram_addr = addr_i[RAM_ADDR_WIDTH-1:0];

    // write lands once the pins have been stable all cycle
    always_ff @(posedge cpu_clock_ne) begin
        if (phi2_fall_i && !we_n_i) begin
            mem[ram_addr] <= data_i;
        end
    end

    // registered read, follows the address every system cycle
    always_ff @(posedge cpu_clock_ne) begin
        rdata_o <= mem[ram_addr];
    end

endmodule

//--- hw/phi2_gen.sv
// ******************************
// phi2_gen
// divides the system clock down to
// the cpu PHI2 clock and flags the
// system cycle where PHI2 falls
// ******************************

module phi2_gen (
    input  logic cpu_clock_ne,      // system clock
    input  logic arst_n_i,          // async reset, active low
    output logic phi2_o,            // cpu PHI2
    output logic phi2_fall_o        // one cycle pulse as phi2 goes low
);
    import bus_pkg::*;

    logic [PHI2_CNT_WIDTH-1:0] cnt_q;       // phase within the phi2 period
    logic [PHI2_CNT_WIDTH-1:0] cnt_next;

    // wrap at the end of the period
    always_comb begin
        if (cnt_q == PHI2_CNT_WIDTH'(PHI2_DIV - 1)) begin
            cnt_next = '0;
        end else begin
            cnt_next = cnt_q + 1'b1;
        end
    end

    // phase 0 is the first low phase
    // so the fall pulse and the low level are set by the same edge
    always_ff @(posedge cpu_clock_ne or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q       <= '0;
            phi2_o      <= 1'b0;        // cpu clock starts low
            phi2_fall_o <= 1'b0;
        end else begin
            cnt_q       <= cnt_next;
            phi2_o      <= (cnt_next >= PHI2_CNT_WIDTH'(PHI2_HALF)); // high half
            phi2_fall_o <= (cnt_next == '0);                          // back to low half
        end
    end

endmodule

//--- sim/pet_bus_chk.sv
// ******************************
// pet_bus_chk
// concurrent assertions bound into
// the bus arbiter: done, busy, RDY
// timing and host select
// ******************************

module pet_bus_chk (
    input logic                cpu_clock_ne,
    input logic                arst_n_i,
    input logic                phi2_fall_i,
    input logic                host_strobe_i,
    input host_pkg::host_op_e  host_op_i,
    input host_pkg::arb_state_e state_q,
    input logic                host_sel_o,
    input logic                cpu_ready_o,
    input logic                host_busy_o,
    input logic                host_done_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import host_pkg::*;

    logic accept_rw;    // read or write strobe taken while idle
    logic steal_end;    // fall closing a stolen cycle

    assign accept_rw = host_strobe_i && !host_busy_o &&
                       (host_op_i == OP_READ || host_op_i == OP_WRITE);
    assign steal_end = (state_q == ARB_STEAL) && phi2_fall_i;

    // done only right after a steal closes
    done_after_steal: assert property (@(posedge cpu_clock_ne) disable iff (!arst_n_i)
        host_done_o |-> $past(steal_end))
        else $error("host_done_o outside the cycle after a steal");

    // busy comes up on the strobe and stays until the steal ends
    busy_on_accept: assert property (@(posedge cpu_clock_ne) disable iff (!arst_n_i)
        accept_rw |=> host_busy_o)
        else $error("host_busy_o low after an accepted strobe");

    busy_until_done: assert property (@(posedge cpu_clock_ne) disable iff (!arst_n_i)
        (host_busy_o && !steal_end) |=> host_busy_o)
        else $error("host_busy_o dropped before the steal ended");

    // RDY only moves on the edge that sees the fall
    ready_at_fall: assert property (@(posedge cpu_clock_ne) disable iff (!arst_n_i)
        $changed(cpu_ready_o) |-> $past(phi2_fall_i))
        else $error("cpu_ready_o changed away from a phi2 fall");

    sel_holds_cpu: assert property (@(posedge cpu_clock_ne) disable iff (!arst_n_i)
        host_sel_o |-> !cpu_ready_o)
        else $error("host_sel_o high while cpu_ready_o high");

endmodule

bind bus_arbiter pet_bus_chk pet_bus_chk_inst (
    .cpu_clock_ne  (cpu_clock_ne),
    .arst_n_i      (arst_n_i),
    .phi2_fall_i   (phi2_fall_i),
    .host_strobe_i (host_strobe_i),
    .host_op_i     (host_op_i),
    .state_q       (state_q),
    .host_sel_o    (host_sel_o),
    .cpu_ready_o   (cpu_ready_o),
    .host_busy_o   (host_busy_o),
    .host_done_o   (host_done_o)
);

//--- sim/pet_bus_monitor.sv
// ******************************
// pet_bus_monitor
// watches the DUT ports, predicts
// PHI2, RDY, busy, done and the bus
// pins and keeps a model of the RAM
// ******************************

module pet_bus_monitor (
    input  logic                               cpu_clock_ne,
    input  logic                               arst_n_i,
    input  logic [bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [bus_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    input  logic                               cpu_we_n_i,
    input  logic                               cpu_ready_i,
    input  logic                               cpu_clock_i,
    input  logic [bus_pkg::CPU_ADDR_WIDTH-1:0] bus_addr_i,
    input  logic [bus_pkg::DATA_WIDTH-1:0]     bus_data_i,
    input  logic                               bus_we_n_i,
    input  logic [bus_pkg::DATA_WIDTH-1:0]     bus_rdata_i,
    input  logic                               host_strobe_i,
    input  host_pkg::host_op_e                 host_op_i,
    input  logic [bus_pkg::CPU_ADDR_WIDTH-1:0] host_addr_i,
    input  logic [bus_pkg::DATA_WIDTH-1:0]     host_data_i,
    input  logic                               host_busy_i,
    input  logic                               host_done_i,
    input  logic [bus_pkg::DATA_WIDTH-1:0]     host_rdata_i,
    output int                                 error_count_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import bus_pkg::*;
    import host_pkg::*;

    logic [DATA_WIDTH-1:0]     mem_model [RAM_DEPTH];
    logic                      mem_valid [RAM_DEPTH];  // byte written at least once
    int                        phase;                   // expected PHI2 phase
    logic                      phi2_prev;
    logic                      load_next;               // pins load at the next edge
    logic                      pend, steal;             // host request model
    logic                      hold_req, hold_cur;
    logic [CPU_ADDR_WIDTH-1:0] req_addr;
    logic [DATA_WIDTH-1:0]     req_data;
    logic                      req_we;
    logic                      ready_exp, busy_exp, done_exp;
    logic [CPU_ADDR_WIDTH-1:0] addr_exp;
    logic [DATA_WIDTH-1:0]     data_exp;
    logic                      we_n_exp;
    logic [DATA_WIDTH-1:0]     rdata_exp;
    logic                      rdata_known;

    task automatic report_fail(input string msg);
        error_count_o++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    initial begin
        error_count_o = 0;
        for (int i = 0; i < RAM_DEPTH; i++) begin
            mem_valid[i] = 1'b0;    // ram powers up unknown
        end
    end

    always @(posedge cpu_clock_ne) begin : model
        logic                      fall;
        logic                      accept;
        logic                      phi2_exp;
        logic [RAM_ADDR_WIDTH-1:0] a;
        if (!arst_n_i) begin
            phase     = 0;
            phi2_prev = 1'b0;
            load_next = 1'b0;
            pend      = 1'b0;
            steal     = 1'b0;
            hold_req  = 1'b0;
            hold_cur  = 1'b0;
            ready_exp = 1'b1;
            busy_exp  = 1'b0;
            done_exp  = 1'b0;
            addr_exp  = '0;
            data_exp  = '0;
            we_n_exp  = 1'b1;
            rdata_known = 1'b0;
        end else begin
            // low for the first half of each period, starting low after reset
            phi2_exp = (phase >= PHI2_HALF);
            if (cpu_clock_i !== phi2_exp)
                report_fail($sformatf("cpu_clock_o %b, expected %b", cpu_clock_i, phi2_exp));
            phase = (phase + 1) % PHI2_DIV;

            fall      = phi2_prev && !cpu_clock_i;    // first low sample
            phi2_prev = cpu_clock_i;
            accept    = host_strobe_i && !(pend || steal);

            // outputs against what was predicted at the last edge
            if (cpu_ready_i !== ready_exp)
                report_fail($sformatf("cpu_ready_o %b, expected %b", cpu_ready_i, ready_exp));
            if (host_busy_i !== busy_exp)
                report_fail($sformatf("host_busy_o %b, expected %b", host_busy_i, busy_exp));
            if (host_done_i !== done_exp)
                report_fail($sformatf("host_done_o %b, expected %b", host_done_i, done_exp));
            if (bus_addr_i !== addr_exp || bus_data_i !== data_exp || bus_we_n_i !== we_n_exp)
                report_fail($sformatf("bus pins %h/%h/%b, expected %h/%h/%b",
                    bus_addr_i, bus_data_i, bus_we_n_i, addr_exp, data_exp, we_n_exp));
            if (done_exp && rdata_known && host_rdata_i !== rdata_exp)
                report_fail($sformatf("host_rdata_o %h, expected %h", host_rdata_i, rdata_exp));

            done_exp = 1'b0;
            // pins take their source one cycle after the fall
            if (load_next) begin
                if (steal) begin
                    addr_exp = req_addr;
                    data_exp = req_data;
                    we_n_exp = !req_we;
                end else begin
                    addr_exp = cpu_addr_i;
                    data_exp = cpu_data_i;
                    we_n_exp = cpu_we_n_i;
                end
            end
            load_next = fall;

            if (fall) begin
                a = bus_addr_i[RAM_ADDR_WIDTH-1:0];     // mirrored byte
                if (mem_valid[a] && bus_rdata_i !== mem_model[a])
                    report_fail($sformatf("bus_rdata_o %h at %h, expected %h",
                        bus_rdata_i, bus_addr_i, mem_model[a]));
                if (steal) begin
                    steal       = 1'b0;                 // this fall closes the steal
                    done_exp    = 1'b1;
                    rdata_exp   = mem_model[a];
                    rdata_known = mem_valid[a];
                end else if (pend) begin
                    pend  = 1'b0;
                    steal = 1'b1;
                end
                if (!bus_we_n_i) begin
                    mem_model[a] = bus_data_i;          // commit at end of cycle
                    mem_valid[a] = 1'b1;
                end
            end

            if (accept) begin
                case (host_op_i)
                    OP_READ, OP_WRITE: begin
                        req_addr = host_addr_i;
                        req_data = host_data_i;
                        req_we   = (host_op_i == OP_WRITE);
                        if (fall) steal = 1'b1;         // claims the cycle just opened
                        else pend = 1'b1;
                    end
                    OP_HOLD: hold_req = 1'b1;
                    OP_RUN:  hold_req = 1'b0;
                    default: ;
                endcase
            end
            if (fall) hold_cur = hold_req;

            ready_exp = !(steal || hold_cur);
            busy_exp  = pend || steal;
        end
    end

endmodule

//--- sim/pet_bus_tb.sv
// ******************************
// pet_bus_tb
// plays the cpu and the host with
// random traffic and reports status
// ******************************

module pet_bus_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import bus_pkg::*;
    import host_pkg::*;

    localparam int DONE_LIMIT = 2 * PHI2_DIV + 4;   // strobe to done, in system cycles
    localparam int BUSY_LIMIT = 4 * PHI2_DIV;

    logic                      cpu_clock_ne;
    logic                      arst_n_i;
    logic [CPU_ADDR_WIDTH-1:0] cpu_addr_i;
    logic [DATA_WIDTH-1:0]     cpu_data_i;
    logic                      cpu_we_n_i;
    logic                      cpu_ready_o;
    logic                      cpu_clock_o;
    logic [CPU_ADDR_WIDTH-1:0] bus_addr_o;
    logic [DATA_WIDTH-1:0]     bus_data_o;
    logic                      bus_we_n_o;
    logic [DATA_WIDTH-1:0]     bus_rdata_o;
    logic                      host_strobe_i;
    host_op_e                  host_op_i;
    logic [CPU_ADDR_WIDTH-1:0] host_addr_i;
    logic [DATA_WIDTH-1:0]     host_data_i;
    logic                      host_busy_o;
    logic                      host_done_o;
    logic [DATA_WIDTH-1:0]     host_rdata_o;
    int                        mismatch_count;
    int                        timeout_count;
    logic                      phi2_seen;

    pet_bus_top pet_bus_top_inst (.*);

    pet_bus_monitor pet_bus_monitor_inst (
        .cpu_clock_ne (cpu_clock_ne), .arst_n_i (arst_n_i),
        .cpu_addr_i (cpu_addr_i), .cpu_data_i (cpu_data_i), .cpu_we_n_i (cpu_we_n_i),
        .cpu_ready_i (cpu_ready_o), .cpu_clock_i (cpu_clock_o),
        .bus_addr_i (bus_addr_o), .bus_data_i (bus_data_o), .bus_we_n_i (bus_we_n_o),
        .bus_rdata_i (bus_rdata_o),
        .host_strobe_i (host_strobe_i), .host_op_i (host_op_i),
        .host_addr_i (host_addr_i), .host_data_i (host_data_i),
        .host_busy_i (host_busy_o), .host_done_i (host_done_o),
        .host_rdata_i (host_rdata_o),
        .error_count_o (mismatch_count)
    );

    // 16 locations spread over the mirrors so bytes get reused
    function automatic logic [CPU_ADDR_WIDTH-1:0] pick_addr();
        logic [3:0] hi;
        logic [3:0] lo;
        hi = 4'($urandom);
        lo = 4'($urandom);
        return {hi, 8'h00, lo};
    endfunction

    initial begin
        cpu_clock_ne = 1'b0;
        forever #50 cpu_clock_ne = !cpu_clock_ne;
    end

    // cpu puts out a new cycle when it sees PHI2 rise
    always @(posedge cpu_clock_ne) begin
        if (arst_n_i) begin
            if (cpu_clock_o && !phi2_seen) begin
                cpu_addr_i <= pick_addr();
                cpu_data_i <= 8'($urandom);
                cpu_we_n_i <= cpu_ready_o ? ($urandom % 3 != 0) : 1'b1;  // no writes when held
            end
            phi2_seen <= cpu_clock_o;
        end
    end

    task automatic send_command(input host_op_e op);
        int n;
        n = 0;
        @(posedge cpu_clock_ne);
        while (host_busy_o && n < BUSY_LIMIT) begin
            @(posedge cpu_clock_ne);
            n++;
        end
        if (n >= BUSY_LIMIT) begin
            $display("timeout: host_busy_o stuck high at %0t", $time);
            timeout_count++;
        end
        host_strobe_i <= 1'b1;
        host_op_i     <= op;
        host_addr_i   <= pick_addr();
        host_data_i   <= 8'($urandom);
        @(posedge cpu_clock_ne);
        host_strobe_i <= 1'b0;
        host_op_i     <= OP_NOP;
        if (op == OP_READ || op == OP_WRITE) begin
            n = 0;
            while (!host_done_o && n < DONE_LIMIT) begin
                @(posedge cpu_clock_ne);
                n++;
            end
            if (!host_done_o) begin
                $display("timeout: no host_done_o within two PHI2 cycles at %0t", $time);
                timeout_count++;
            end
        end
    endtask

    initial begin
        int pick;
        void'($urandom(10));
        timeout_count = 0;
        arst_n_i      = 1'b0;
        cpu_addr_i    = '0;
        cpu_data_i    = '0;
        cpu_we_n_i    = 1'b1;
        host_strobe_i = 1'b0;
        host_op_i     = OP_NOP;
        host_addr_i   = '0;
        host_data_i   = '0;
        phi2_seen     = 1'b0;
        repeat (5) @(posedge cpu_clock_ne);
        arst_n_i <= 1'b1;
        repeat (3 * PHI2_DIV) @(posedge cpu_clock_ne);   // idle cpu traffic first

        for (int i = 0; i < 200; i++) begin
            repeat ($urandom % 30) @(posedge cpu_clock_ne);
            pick = $urandom % 10;
            if (pick == 0) send_command(OP_HOLD);
            else if (pick == 1) send_command(OP_RUN);
            else if (pick < 6) send_command(OP_READ);
            else send_command(OP_WRITE);
        end
        send_command(OP_RUN);
        repeat (4 * PHI2_DIV) @(posedge cpu_clock_ne);

        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
hw/bus_pkg.sv
hw/host_pkg.sv
hw/phi2_gen.sv
hw/bus_arbiter.sv
hw/bus_pins.sv
hw/pet_ram.sv
hw/pet_bus_top.sv
sim/pet_bus_chk.sv
sim/pet_bus_monitor.sv
sim/pet_bus_tb.sv
